// File: ethRxPkg.sv
`default_nettype none

package ethRxPkg;

  // Receive FSM states, DataLow carries the first nibble of each byte
  typedef enum logic [2:0] {
    Idle     = 3'd0,
    Drop     = 3'd1,
    Preamble = 3'd2,
    Sfd      = 3'd3,
    DataLow  = 3'd4,
    DataHigh = 3'd5
  } rxStateT;

  // MII nibbles, first bit on the wire is bit 0
  localparam logic [3:0] PreambleNibble = 4'h5;
  localparam logic [3:0] SfdNibble = 4'hD;

  // Sent together with MRxErr for a bad symbol
  localparam logic [3:0] InvalidSymbolNibble = 4'hE;

  // Register value after a good frame and its FCS, MSB first
  localparam logic [31:0] CrcResidue = 32'hC704DD7B;

  localparam int DefaultByteCntWidth = 16;

endpackage

`default_nettype wire

// File: ethRxStateMachine.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxStateMachine (
  input  wire                MRxClk,
  input  wire                Reset,
  input  wire                MRxDV,
  input  wire [3:0]          MRxD,
  output ethRxPkg::rxStateT  rxState
);

  import ethRxPkg::*;

  rxStateT nextState;

  always_comb
  begin
    nextState = rxState;
    case (rxState)
      Idle:
      begin
        if (MRxDV)
          nextState = (MRxD == PreambleNibble) ? Preamble : Drop;
      end
      Drop:
      begin
        if (!MRxDV)
          nextState = Idle;
      end
      Preamble:
      begin
        if (!MRxDV)
          nextState = Idle;
        else if (MRxD == PreambleNibble)
          nextState = Sfd;
        else
          nextState = Drop;
      end
      // Hunting for the delimiter once the preamble is under way
      Sfd:
      begin
        if (!MRxDV)
          nextState = Idle;
        else if (MRxD == SfdNibble)
          nextState = DataLow;
        else if (MRxD != PreambleNibble)
          nextState = Drop;
      end
      DataLow:
      begin
        nextState = MRxDV ? DataHigh : Idle;
      end
      DataHigh:
      begin
        nextState = MRxDV ? DataLow : Idle;
      end
      default:
      begin
        nextState = Idle;
      end
    endcase
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      rxState <= Idle;
    else
      rxState <= nextState;
  end

  // Byte phase never starts anywhere but after the SFD
  assert property (@(posedge MRxClk) disable iff (Reset)
    rxState == DataLow |-> $past(rxState) inside {Sfd, DataHigh})
    else $error("DataLow entered outside the byte sequence");

endmodule

`default_nettype wire

// File: ethRxCounters.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxCounters #(
  parameter int ByteCntWidth = ethRxPkg::DefaultByteCntWidth
) (
  input  wire                     MRxClk,
  input  wire                     Reset,
  input  wire ethRxPkg::rxStateT  rxState,
  input  wire [ByteCntWidth-1:0]  maxFrameLen,
  input  wire                     hugeEnable,
  output logic [ByteCntWidth-1:0] byteCnt,
  output logic                    byteCntEq0,
  output logic                    byteCntMaxFrame
);

  import ethRxPkg::*;

  localparam logic [ByteCntWidth-1:0] CntMax = '1;

  logic cntFull;

  assign cntFull = (byteCnt == CntMax);

  // One count per completed byte, held at all ones on overlong frames
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      byteCnt <= '0;
    else if (rxState == Sfd)
      byteCnt <= '0;
    else if (rxState == DataHigh && !cntFull)
      byteCnt <= byteCnt + 1'b1;
  end

  assign byteCntEq0 = (byteCnt == '0);

  // Jumbo frames never hit the length limit
  assign byteCntMaxFrame = (byteCnt == maxFrameLen) && !hugeEnable;

  // Only the SFD may bring a full counter back to zero
  assert property (@(posedge MRxClk) disable iff (Reset)
    cntFull && rxState != Sfd |=> byteCnt == CntMax)
    else $error("Byte counter wrapped");

endmodule

`default_nettype wire

// File: ethRxCrc.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxCrc (
  input  wire                 MRxClk,
  input  wire                 Reset,
  input  wire ethRxPkg::rxStateT rxState,
  input  wire                 MRxDV,
  input  wire [3:0]           MRxD,
  output logic                crcError
);

  import ethRxPkg::*;

  // IEEE 802.3 polynomial, reflected
  localparam logic [31:0] CrcPoly = 32'hEDB88320;

  logic [31:0] crcReg;
  logic [31:0] crcReversed;

  function automatic logic [31:0] crcNibble(input logic [31:0] crcIn, input logic [3:0] data);
    logic [31:0] crc;
    crc = crcIn;
    // LSB of the nibble is the first bit on the wire
    for (int i = 0; i < 4; i++)
    begin
      if (crc[0] ^ data[i])
        crc = (crc >> 1) ^ CrcPoly;
      else
        crc = crc >> 1;
    end
    return crc;
  endfunction

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      crcReg <= '1;
    else if (rxState == Sfd)
      crcReg <= '1;
    else if ((rxState == DataLow || rxState == DataHigh) && MRxDV)
      crcReg <= crcNibble(crcReg, MRxD);
  end

  // Residue constant is kept MSB first
  assign crcReversed = {<<{crcReg}};
  assign crcError = (crcReversed != CrcResidue);

endmodule

`default_nettype wire

// File: ethRxStatus.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxStatus #(
  parameter int ByteCntWidth = ethRxPkg::DefaultByteCntWidth
) (
  input  wire                     MRxClk,
  input  wire                     Reset,
  input  wire ethRxPkg::rxStateT  rxState,
  input  wire                     MRxDV,
  input  wire                     MRxErr,
  input  wire [3:0]               MRxD,
  input  wire                     Collision,
  input  wire [ByteCntWidth-1:0]  byteCnt,
  input  wire                     byteCntEq0,
  input  wire                     byteCntMaxFrame,
  input  wire                     crcError,
  input  wire [ByteCntWidth-1:0]  minFrameLen,
  input  wire [ByteCntWidth-1:0]  maxFrameLen,
  input  wire [5:0]               collValid,
  input  wire                     hugeEnable,
  input  wire                     recvSmall,
  input  wire                     fullDuplex,
  output logic                    loadRxStatus,
  output logic                    receiveEnd,
  output logic                    latchedCrcError,
  output logic                    receivedPacketGood,
  output logic                    latchedMRxErr,
  output logic                    invalidSymbol,
  output logic                    shortFrame,
  output logic                    tooBig,
  output logic                    dribbleNibble,
  output logic                    rxLateCollision,
  output logic                    receivedLengthOk
);

  import ethRxPkg::*;

  logic dataState;
  logic sfdState;
  logic takeSample;
  logic setInvalidSymbol;
  logic rxColWindow;

  assign dataState = (rxState == DataLow) || (rxState == DataHigh);
  assign sfdState = (rxState == Sfd);

  // End of data or length limit reached with data still coming
  // A frame already reported at the limit is not reported twice in a row
  assign takeSample = (dataState && !MRxDV ||
                       rxState == DataLow && MRxDV && byteCntMaxFrame) && !loadRxStatus;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      loadRxStatus <= 1'b0;
      receiveEnd <= 1'b0;
    end
    else
    begin
      loadRxStatus <= takeSample;
      receiveEnd <= loadRxStatus;
    end
  end

  // CRC checked at every byte boundary so the last one wins
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      latchedCrcError <= 1'b0;
    else if (sfdState)
      latchedCrcError <= 1'b0;
    else if (rxState == DataLow)
      latchedCrcError <= crcError && !byteCntEq0;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      receivedPacketGood <= 1'b0;
    else if (sfdState)
      receivedPacketGood <= 1'b0;
    else if (loadRxStatus)
      receivedPacketGood <= !latchedCrcError;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      latchedMRxErr <= 1'b0;
    else if (MRxErr && MRxDV && rxState != Drop)
      latchedMRxErr <= 1'b1;
    else if (sfdState)
      latchedMRxErr <= 1'b0;
  end

  assign setInvalidSymbol = MRxDV && MRxErr && (MRxD == InvalidSymbolNibble);

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      invalidSymbol <= 1'b0;
    else if (setInvalidSymbol)
      invalidSymbol <= 1'b1;
    else if (sfdState)
      invalidSymbol <= 1'b0;
  end

  // Window closes once collValid bytes went by without a collision
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      rxColWindow <= 1'b1;
    else if (!Collision && byteCnt[5:0] == collValid && rxState == DataHigh)
      rxColWindow <= 1'b0;
    else if (rxState == Idle)
      rxColWindow <= 1'b1;
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      rxLateCollision <= 1'b0;
    else if (sfdState)
      rxLateCollision <= 1'b0;
    else if (Collision && !fullDuplex && dataState && (!rxColWindow || recvSmall))
      rxLateCollision <= 1'b1;
  end

  // Length flags
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      shortFrame <= 1'b0;
      tooBig <= 1'b0;
    end
    else if (sfdState)
    begin
      shortFrame <= 1'b0;
      tooBig <= 1'b0;
    end
    else if (takeSample)
    begin
      shortFrame <= byteCnt < minFrameLen;
      // MRxDV still high here means data beyond maxFrameLen
      tooBig <= MRxDV || (!hugeEnable && byteCnt > maxFrameLen);
    end
  end

  // Odd nibble count
  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      dribbleNibble <= 1'b0;
    else if (sfdState)
      dribbleNibble <= 1'b0;
    else if (!MRxDV && rxState == DataHigh)
      dribbleNibble <= 1'b1;
  end

  assign receivedLengthOk = (byteCnt >= minFrameLen) && (byteCnt <= maxFrameLen);

  assert property (@(posedge MRxClk) disable iff (Reset)
    loadRxStatus |=> receiveEnd && !loadRxStatus)
    else $error("loadRxStatus not followed by a single receiveEnd");

endmodule

`default_nettype wire

// File: ethRxTop.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxTop #(
  parameter int ByteCntWidth = ethRxPkg::DefaultByteCntWidth
) (
  input  wire                     MRxClk,
  input  wire                     Reset,
  input  wire                     MRxDV,
  input  wire [3:0]               MRxD,
  input  wire                     MRxErr,
  input  wire                     Collision,
  input  wire [ByteCntWidth-1:0]  minFrameLen,
  input  wire [ByteCntWidth-1:0]  maxFrameLen,
  input  wire [5:0]               collValid,
  input  wire                     hugeEnable,
  input  wire                     recvSmall,
  input  wire                     fullDuplex,
  output logic                    loadRxStatus,
  output logic                    receiveEnd,
  output logic                    latchedCrcError,
  output logic                    receivedPacketGood,
  output logic                    latchedMRxErr,
  output logic                    invalidSymbol,
  output logic                    shortFrame,
  output logic                    tooBig,
  output logic                    dribbleNibble,
  output logic                    rxLateCollision,
  output logic                    receivedLengthOk
);

  import ethRxPkg::*;

  rxStateT                 rxState;
  logic [ByteCntWidth-1:0] byteCnt;
  logic                    byteCntEq0;
  logic                    byteCntMaxFrame;
  logic                    crcError;

  ethRxStateMachine ethRxStateMachine_inst (.*);

  ethRxCounters #(
    .ByteCntWidth(ByteCntWidth)
  ) ethRxCounters_inst (.*);

  ethRxCrc ethRxCrc_inst (.*);

  ethRxStatus #(
    .ByteCntWidth(ByteCntWidth)
  ) ethRxStatus_inst (.*);

endmodule

`default_nettype wire

// File: ethRxTb.sv
`timescale 1ns/1ps
`default_nettype none

module ethRxTb;

  import ethRxPkg::*;

  localparam int ByteCntWidth = DefaultByteCntWidth;
  localparam int ClkPeriod = 8;
  localparam int DriveDelay = 1;
  localparam int EndTimeout = 200;
  localparam int LoadTimeout = 4000;
  localparam int NoByte = -1;

  logic                    MRxClk;
  logic                    Reset;
  logic                    MRxDV;
  logic [3:0]              MRxD;
  logic                    MRxErr;
  logic                    Collision;
  logic [ByteCntWidth-1:0] minFrameLen;
  logic [ByteCntWidth-1:0] maxFrameLen;
  logic [5:0]              collValid;
  logic                    hugeEnable;
  logic                    recvSmall;
  logic                    fullDuplex;
  logic                    loadRxStatus;
  logic                    receiveEnd;
  logic                    latchedCrcError;
  logic                    receivedPacketGood;
  logic                    latchedMRxErr;
  logic                    invalidSymbol;
  logic                    shortFrame;
  logic                    tooBig;
  logic                    dribbleNibble;
  logic                    rxLateCollision;
  logic                    receivedLengthOk;

  logic [31:0]             lfsr;
  logic [ByteCntWidth-1:0] wireByte;
  int                      errByte;
  int                      collByte;
  bit                      dribble;
  bit                      flipFcs;
  bit                      endSeen;
  bit                      loadBeforeEnd;
  int                      loadPulses;
  int                      passCount;
  int                      failCount;

  ethRxTop #(
    .ByteCntWidth(ByteCntWidth)
  ) ethRxTop_inst (.*);

  initial
  begin
    MRxClk = 1'b0;
    forever #(ClkPeriod / 2) MRxClk = ~MRxClk;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randomByte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsrNext(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  // MSB-first CRC-32 stepped one wire bit at a time
  function automatic logic [31:0] crcBit(input logic [31:0] crc, input logic d);
    logic [31:0] c;
    c = crc << 1;
    if (crc[31] ^ d)
      c = c ^ 32'h04C11DB7;
    return c;
  endfunction

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got === exp)
      passCount++;
    else
    begin
      failCount++;
      $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic checkCount(input logic [ByteCntWidth-1:0] got,
                            input logic [ByteCntWidth-1:0] exp, input string what);
    if (got === exp)
      passCount++;
    else
    begin
      failCount++;
      $display("FAILED at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic driveMii(input logic dv, input logic [3:0] d, input logic err,
                          input logic coll);
    @(posedge MRxClk);
    #DriveDelay;
    MRxDV = dv;
    MRxD = d;
    MRxErr = err;
    Collision = coll;
  endtask

  task automatic applyConfig(input logic huge, input logic duplex);
    @(posedge MRxClk);
    #DriveDelay;
    hugeEnable = huge;
    fullDuplex = duplex;
  endtask

  task automatic waitFrameEnd();
    bit prevLoad;
    prevLoad = 1'b0;
    endSeen = 1'b0;
    loadPulses = 0;
    loadBeforeEnd = 1'b0;
    for (int i = 0; i < EndTimeout && !endSeen; i++)
    begin
      @(negedge MRxClk);
      if (receiveEnd)
      begin
        endSeen = 1'b1;
        loadBeforeEnd = prevLoad;
      end
      if (loadRxStatus)
        loadPulses++;
      prevLoad = loadRxStatus;
    end
    if (!endSeen)
    begin
      failCount++;
      $display("No end of frame arrived within %0d cycles at %0d ns", EndTimeout, $time);
    end
  endtask

  // len counts the FCS bytes too
  task automatic sendFrame(input int len);
    logic [7:0]  frame[$];
    logic [7:0]  b;
    logic [31:0] crc;
    logic [31:0] fcsWire;
    crc = '1;
    for (int i = 0; i < len - 4; i++)
    begin
      randomByte(b);
      frame.push_back(b);
      for (int k = 0; k < 8; k++)
        crc = crcBit(crc, b[k]);
    end
    crc = ~crc;
    fcsWire = {<<{crc}};
    if (flipFcs)
      fcsWire[5] = ~fcsWire[5];
    for (int k = 0; k < 4; k++)
      frame.push_back(fcsWire[8*k +: 8]);
    repeat (4) driveMii(1'b0, 4'h0, 1'b0, 1'b0);
    repeat (15) driveMii(1'b1, PreambleNibble, 1'b0, 1'b0);
    driveMii(1'b1, SfdNibble, 1'b0, 1'b0);
    foreach (frame[i])
    begin
      driveMii(1'b1, (i == errByte) ? InvalidSymbolNibble : frame[i][3:0],
               i == errByte, i == collByte);
      wireByte = ByteCntWidth'(i);
      driveMii(1'b1, frame[i][7:4], 1'b0, i == collByte);
    end
    if (dribble)
      driveMii(1'b1, 4'h0, 1'b0, 1'b0);
    driveMii(1'b0, 4'h0, 1'b0, 1'b0);
    waitFrameEnd();
  endtask

  // Length limit reached while data is still arriving
  task automatic watchEarlyLoad();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < LoadTimeout && !seen; i++)
    begin
      @(negedge MRxClk);
      if (loadRxStatus)
      begin
        seen = 1'b1;
        checkBit(MRxDV, 1'b1, "MRxDV at early loadRxStatus");
        checkCount(wireByte, maxFrameLen, "byte on the wire at early loadRxStatus");
      end
    end
    if (!seen)
    begin
      failCount++;
      $display("No loadRxStatus arrived during the oversized frame");
    end
  endtask

  task automatic checkNoErrors();
    checkBit(latchedCrcError, 1'b0, "latchedCrcError");
    checkBit(latchedMRxErr, 1'b0, "latchedMRxErr");
    checkBit(invalidSymbol, 1'b0, "invalidSymbol");
    checkBit(shortFrame, 1'b0, "shortFrame");
    checkBit(tooBig, 1'b0, "tooBig");
    checkBit(dribbleNibble, 1'b0, "dribbleNibble");
    checkBit(rxLateCollision, 1'b0, "rxLateCollision");
  endtask

  task automatic reportTest(input string name, input int failsBefore);
    if (failCount == failsBefore)
      $display("%s: passed", name);
    else
      $display("%s: %0d check(s) failed", name, failCount - failsBefore);
  endtask

  task automatic goodFrameTest();
    int fails;
    fails = failCount;
    sendFrame(64);
    checkBit(endSeen, 1'b1, "receiveEnd seen");
    checkBit(loadPulses == 1, 1'b1, "single loadRxStatus pulse");
    checkBit(loadBeforeEnd, 1'b1, "loadRxStatus one cycle before receiveEnd");
    checkBit(receivedPacketGood, 1'b1, "receivedPacketGood");
    checkBit(receivedLengthOk, 1'b1, "receivedLengthOk");
    checkNoErrors();
    reportTest("good frame", fails);
  endtask

  task automatic crcErrorTest();
    int fails;
    fails = failCount;
    flipFcs = 1'b1;
    sendFrame(64);
    flipFcs = 1'b0;
    checkBit(latchedCrcError, 1'b1, "latchedCrcError");
    checkBit(receivedPacketGood, 1'b0, "receivedPacketGood");
    reportTest("bad FCS", fails);
  endtask

  task automatic lengthTest();
    int fails;
    fails = failCount;
    sendFrame(40);
    checkBit(shortFrame, 1'b1, "shortFrame on 40 bytes");
    fork
      sendFrame(1600);
      watchEarlyLoad();
    join
    checkBit(tooBig, 1'b1, "tooBig on 1600 bytes");
    applyConfig(1'b1, 1'b0);
    sendFrame(1600);
    checkBit(tooBig, 1'b0, "tooBig with hugeEnable");
    applyConfig(1'b0, 1'b0);
    reportTest("frame length", fails);
  endtask

  task automatic invalidSymbolTest();
    int fails;
    fails = failCount;
    errByte = 20;
    sendFrame(64);
    errByte = NoByte;
    checkBit(invalidSymbol, 1'b1, "invalidSymbol");
    checkBit(latchedMRxErr, 1'b1, "latchedMRxErr");
    reportTest("invalid symbol", fails);
  endtask

  task automatic dribbleTest();
    int fails;
    fails = failCount;
    dribble = 1'b1;
    sendFrame(64);
    dribble = 1'b0;
    checkBit(dribbleNibble, 1'b1, "dribbleNibble on odd nibbles");
    sendFrame(64);
    checkBit(dribbleNibble, 1'b0, "dribbleNibble on next clean frame");
    reportTest("dribble nibble", fails);
  endtask

  task automatic collisionTest();
    int fails;
    fails = failCount;
    collByte = 80;
    sendFrame(128);
    checkBit(rxLateCollision, 1'b1, "rxLateCollision at byte 80");
    collByte = 10;
    sendFrame(128);
    checkBit(rxLateCollision, 1'b0, "rxLateCollision at byte 10");
    collByte = 80;
    applyConfig(1'b0, 1'b1);
    sendFrame(128);
    checkBit(rxLateCollision, 1'b0, "rxLateCollision in full duplex");
    applyConfig(1'b0, 1'b0);
    collByte = NoByte;
    reportTest("late collision", fails);
  endtask

  initial
  begin
    Reset = 1'b1;
    MRxDV = 1'b0;
    MRxD = 4'h0;
    MRxErr = 1'b0;
    Collision = 1'b0;
    minFrameLen = ByteCntWidth'(64);
    maxFrameLen = ByteCntWidth'(1518);
    collValid = 6'd63;
    hugeEnable = 1'b0;
    recvSmall = 1'b0;
    fullDuplex = 1'b0;
    lfsr = 32'h43bd;
    wireByte = '0;
    errByte = NoByte;
    collByte = NoByte;
    dribble = 1'b0;
    flipFcs = 1'b0;
    passCount = 0;
    failCount = 0;
    repeat (5) @(posedge MRxClk);
    #DriveDelay;
    Reset = 1'b0;
    checkBit(loadRxStatus || receiveEnd || receivedPacketGood, 1'b0, "strobes after reset");
    goodFrameTest();
    crcErrorTest();
    lengthTest();
    invalidSymbolTest();
    dribbleTest();
    collisionTest();
    $display("Checks passed: %0d, failed: %0d", passCount, failCount);
    if (failCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: ethRxTop.f
ethRxPkg.sv
ethRxStateMachine.sv
ethRxCounters.sv
ethRxCrc.sv
ethRxStatus.sv
ethRxTop.sv
ethRxTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ethRxTb
FILELIST ?= ethRxTop.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
